//--- ahb_pkg.sv
// AHB-Lite bus definitions
// Widths, typed vectors, transfer and size encodings, response values
`default_nettype none

package ahb_pkg;

  // Bus widths
  localparam int AHB_ADDR_W = 32;
  localparam int AHB_DATA_W = 32;

  typedef logic [AHB_ADDR_W-1:0] haddr_t;
  typedef logic [AHB_DATA_W-1:0] hdata_t;

  // HTRANS encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // HSIZE encoding, only up to bus width
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // HRESP values
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

endpackage

`default_nettype wire

//--- amap_pkg.sv
// Address map of the interconnect node
// Subordinate count, fixed register window, reset windows, register offsets
`default_nettype none

package amap_pkg;

  localparam int NB_SUBS = 3;

  // One select bit per subordinate
  typedef logic [NB_SUBS-1:0] sub_sel_t;

  // Fixed window of the map register block
  localparam ahb_pkg::haddr_t REGS_START = 32'h0000_0000;
  localparam ahb_pkg::haddr_t REGS_END   = 32'h0000_00FF;

  // Reset windows of the two memories
  localparam ahb_pkg::haddr_t RST_START1 = 32'h0000_1000;
  localparam ahb_pkg::haddr_t RST_END1   = 32'h0000_1FFF;
  localparam ahb_pkg::haddr_t RST_START2 = 32'h0000_2000;
  localparam ahb_pkg::haddr_t RST_END2   = 32'h0000_2FFF;

  // Register offsets inside the map block
  localparam logic [7:0] OFS_START1 = 8'h00;
  localparam logic [7:0] OFS_END1   = 8'h04;
  localparam logic [7:0] OFS_START2 = 8'h08;
  localparam logic [7:0] OFS_END2   = 8'h0C;

endpackage

`default_nettype wire

//--- ahb_node.sv
// AHB-Lite interconnect node, one master to three subordinates
// Decodes address windows, forms window offsets, muxes data-phase response
// Unmapped transfers get a two-cycle ERROR from an internal default subordinate
`timescale 1ns/1ns
`default_nettype none

module ahb_node (
  input  wire logic                                      hclk,
  input  wire logic                                      reset_i,
  // Master side
  input  wire ahb_pkg::haddr_t                           haddr_i,
  input  wire ahb_pkg::hdata_t                           hwdata_i,
  input  wire logic                                      hsel_i,
  input  wire logic                                      hwrite_i,
  input  wire ahb_pkg::htrans_e                          htrans_i,
  input  wire ahb_pkg::hsize_e                           hsize_i,
  output      ahb_pkg::hdata_t                           hrdata_o,
  output      logic                                      hready_o,
  output      logic                                      hresp_o,
  // Toward the subordinates
  output      ahb_pkg::haddr_t  [amap_pkg::NB_SUBS-1:0]  sub_haddr_o,
  output      ahb_pkg::hdata_t  [amap_pkg::NB_SUBS-1:0]  sub_hwdata_o,
  output      amap_pkg::sub_sel_t                        sub_hsel_o,
  output      logic             [amap_pkg::NB_SUBS-1:0]  sub_hwrite_o,
  output      ahb_pkg::htrans_e [amap_pkg::NB_SUBS-1:0]  sub_htrans_o,
  output      ahb_pkg::hsize_e  [amap_pkg::NB_SUBS-1:0]  sub_hsize_o,
  output      logic             [amap_pkg::NB_SUBS-1:0]  sub_hready_o,
  // From the subordinates
  input  wire ahb_pkg::hdata_t  [amap_pkg::NB_SUBS-1:0]  sub_hrdata_i,
  input  wire logic             [amap_pkg::NB_SUBS-1:0]  sub_hreadyout_i,
  input  wire logic             [amap_pkg::NB_SUBS-1:0]  sub_hresp_i,
  // Programmable windows of subordinates 1 and 2
  input  wire ahb_pkg::haddr_t  [2:1]                    start_addr_i,
  input  wire ahb_pkg::haddr_t  [2:1]                    end_addr_i
);
  import ahb_pkg::*;
  import amap_pkg::*;

  // Default subordinate ERROR cycles
  typedef enum logic {
    ERR_CYC1,
    ERR_CYC2
  } err_state_e;

  haddr_t     win_lo [NB_SUBS];
  haddr_t     win_hi [NB_SUBS];
  sub_sel_t   sel;
  logic       accept;
  sub_sel_t   dp_sel_q;
  logic       dp_def_q;
  err_state_e err_q;

  // Empty window when end is below start
  function automatic logic in_win(haddr_t addr, haddr_t lo, haddr_t hi);
    return (lo <= hi) && (addr >= lo) && (addr <= hi);
  endfunction

  // Window table, index 0 is fixed
  always_comb begin
    win_lo[0] = REGS_START;
    win_hi[0] = REGS_END;
    win_lo[1] = start_addr_i[1];
    win_hi[1] = end_addr_i[1];
    win_lo[2] = start_addr_i[2];
    win_hi[2] = end_addr_i[2];
  end

  // Lowest index match wins
  always_comb begin
    sel = '0;
    for (int i = 0; i < NB_SUBS; i++) begin
      if (sel == '0 && in_win(haddr_i, win_lo[i], win_hi[i])) begin
        sel[i] = 1'b1;
      end
    end
  end

  assign sub_hsel_o = hsel_i ? sel : '0;
  assign accept = hsel_i && hready_o && (htrans_i == NONSEQ || htrans_i == SEQ);

  // Offset per window plus broadcast of the rest
  always_comb begin
    for (int i = 0; i < NB_SUBS; i++) begin
      sub_haddr_o[i]  = haddr_i - win_lo[i];
      sub_hwdata_o[i] = hwdata_i;
      sub_hwrite_o[i] = hwrite_i;
      sub_htrans_o[i] = htrans_i;
      sub_hsize_o[i]  = hsize_i;
      sub_hready_o[i] = hready_o;
    end
  end

  // Data-phase owner, updated whenever the bus is ready
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      dp_sel_q <= '0;
      dp_def_q <= 1'b0;
    end else if (hready_o) begin
      if (accept) begin
        dp_sel_q <= sel;
        // Nothing matched so the default subordinate owns it
        dp_def_q <= ~|sel;
      end else begin
        dp_sel_q <= '0;
        dp_def_q <= 1'b0;
      end
    end
  end

  // Two-cycle ERROR sequence
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      err_q <= ERR_CYC1;
    end else if (dp_def_q) begin
      err_q <= (err_q == ERR_CYC1) ? ERR_CYC2 : ERR_CYC1;
    end
  end

  // Response mux, idle bus is OKAY and ready
  always_comb begin
    hrdata_o = '0;
    hready_o = 1'b1;
    hresp_o  = HRESP_OKAY;
    if (dp_def_q) begin
      hresp_o  = HRESP_ERROR;
      hready_o = (err_q == ERR_CYC2);
    end else begin
      for (int i = 0; i < NB_SUBS; i++) begin
        if (dp_sel_q[i]) begin
          hrdata_o = sub_hrdata_i[i];
          hready_o = sub_hreadyout_i[i];
          hresp_o  = sub_hresp_i[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- ahb_amap_regs.sv
// Address map register block, AHB-Lite subordinate 0
// Holds start and end of the memory windows that steer the node decoder
// Zero wait states, always OKAY
`timescale 1ns/1ns
`default_nettype none

module ahb_amap_regs (
  input  wire logic                  hclk,
  input  wire logic                  reset_i,
  input  wire ahb_pkg::haddr_t       haddr_i,
  input  wire ahb_pkg::hdata_t       hwdata_i,
  input  wire logic                  hsel_i,
  input  wire logic                  hwrite_i,
  input  wire ahb_pkg::htrans_e      htrans_i,
  input  wire logic                  hready_i,
  output      ahb_pkg::hdata_t       hrdata_o,
  output      logic                  hreadyout_o,
  output      logic                  hresp_o,
  output      ahb_pkg::haddr_t [2:1] start_addr_o,
  output      ahb_pkg::haddr_t [2:1] end_addr_o
);
  import ahb_pkg::*;
  import amap_pkg::*;

  logic       accept;
  logic       dp_valid_q;
  logic       dp_write_q;
  logic [7:0] dp_ofs_q;

  assign accept = hsel_i && hready_i && (htrans_i == NONSEQ || htrans_i == SEQ);

  // Address phase capture
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      dp_valid_q <= 1'b0;
      dp_write_q <= 1'b0;
      dp_ofs_q   <= '0;
    end else if (hready_i) begin
      dp_valid_q <= accept;
      dp_write_q <= hwrite_i;
      // Window is 256 bytes wide
      dp_ofs_q   <= haddr_i[7:0];
    end
  end

  // Register write in the data phase
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      start_addr_o[1] <= RST_START1;
      end_addr_o[1]   <= RST_END1;
      start_addr_o[2] <= RST_START2;
      end_addr_o[2]   <= RST_END2;
    end else if (dp_valid_q && dp_write_q) begin
      case (dp_ofs_q)
        OFS_START1: start_addr_o[1] <= hwdata_i;
        OFS_END1:   end_addr_o[1]   <= hwdata_i;
        OFS_START2: start_addr_o[2] <= hwdata_i;
        OFS_END2:   end_addr_o[2]   <= hwdata_i;
        default: ;
      endcase
    end
  end

  // Read mux, unused offsets read zero
  always_comb begin
    case (dp_ofs_q)
      OFS_START1: hrdata_o = start_addr_o[1];
      OFS_END1:   hrdata_o = end_addr_o[1];
      OFS_START2: hrdata_o = start_addr_o[2];
      OFS_END2:   hrdata_o = end_addr_o[2];
      default:    hrdata_o = '0;
    endcase
  end

  // No wait states, no errors
  assign hreadyout_o = 1'b1;
  assign hresp_o     = HRESP_OKAY;

endmodule

`default_nettype wire

//--- ahb_sram_sub.sv
// Word memory AHB-Lite subordinate
// Byte, halfword and word writes with fixed wait states before each ready cycle
`timescale 1ns/1ns
`default_nettype none

module ahb_sram_sub #(
  parameter int WAIT_STATES = 0,
  parameter int MEM_WORDS   = 1024
) (
  input  wire logic             hclk,
  input  wire logic             reset_i,
  input  wire ahb_pkg::haddr_t  haddr_i,
  input  wire ahb_pkg::hdata_t  hwdata_i,
  input  wire logic             hsel_i,
  input  wire logic             hwrite_i,
  input  wire ahb_pkg::htrans_e htrans_i,
  input  wire ahb_pkg::hsize_e  hsize_i,
  input  wire logic             hready_i,
  output      ahb_pkg::hdata_t  hrdata_o,
  output      logic             hreadyout_o,
  output      logic             hresp_o
);
  import ahb_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  hdata_t             mem [MEM_WORDS];
  logic               accept;
  logic               dp_valid_q;
  logic               dp_write_q;
  hsize_e             dp_size_q;
  logic [IDX_W-1:0]   dp_idx_q;
  logic [1:0]         dp_lo_q;
  logic [CNT_W-1:0]   wait_cnt_q;
  logic [3:0]         lane_en;

  // Lanes touched by size and low address bits
  function automatic logic [3:0] lanes(hsize_e size, logic [1:0] lo);
    case (size)
      BYTE:    return 4'b0001 << lo;
      HALF:    return lo[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  assign accept = hsel_i && hready_i && (htrans_i == NONSEQ || htrans_i == SEQ);

  // Capture on accept and count wait states while stalled
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      dp_valid_q <= 1'b0;
      wait_cnt_q <= '0;
    end else if (hready_i) begin
      dp_valid_q <= accept;
      wait_cnt_q <= '0;
    end else if (dp_valid_q && !hreadyout_o) begin
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end
  end

  // Attributes of the accepted transfer
  always_ff @(posedge hclk) begin
    if (accept) begin
      dp_write_q <= hwrite_i;
      dp_size_q  <= hsize_i;
      // Modulo MEM_WORDS by truncation
      dp_idx_q   <= haddr_i[IDX_W+1:2];
      dp_lo_q    <= haddr_i[1:0];
    end
  end

  assign hreadyout_o = !dp_valid_q || (wait_cnt_q == CNT_W'(WAIT_STATES));
  assign lane_en     = lanes(dp_size_q, dp_lo_q);

  // Storage cleared on reset and written on the ready cycle
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (dp_valid_q && dp_write_q && hreadyout_o) begin
      for (int b = 0; b < 4; b++) begin
        if (lane_en[b]) begin
          mem[dp_idx_q][8*b +: 8] <= hwdata_i[8*b +: 8];
        end
      end
    end
  end

  assign hrdata_o = mem[dp_idx_q];
  assign hresp_o  = HRESP_OKAY;

endmodule

`default_nettype wire

//--- ahb_node_wrap.sv
// Top level of the AHB-Lite node
// Node plus map register block and two memories with different wait states
`timescale 1ns/1ns
`default_nettype none

module ahb_node_wrap (
  input  wire logic             hclk,
  input  wire logic             reset_i,
  input  wire ahb_pkg::haddr_t  haddr_i,
  input  wire ahb_pkg::hdata_t  hwdata_i,
  input  wire logic             hsel_i,
  input  wire logic             hwrite_i,
  input  wire ahb_pkg::htrans_e htrans_i,
  input  wire ahb_pkg::hsize_e  hsize_i,
  output      ahb_pkg::hdata_t  hrdata_o,
  output      logic             hready_o,
  output      logic             hresp_o
);
  import ahb_pkg::*;
  import amap_pkg::*;

  // Subordinate-side vectors
  haddr_t  [NB_SUBS-1:0] sub_haddr;
  hdata_t  [NB_SUBS-1:0] sub_hwdata;
  sub_sel_t              sub_hsel;
  logic    [NB_SUBS-1:0] sub_hwrite;
  htrans_e [NB_SUBS-1:0] sub_htrans;
  hsize_e  [NB_SUBS-1:0] sub_hsize;
  logic    [NB_SUBS-1:0] sub_hready;
  hdata_t  [NB_SUBS-1:0] sub_hrdata;
  logic    [NB_SUBS-1:0] sub_hreadyout;
  logic    [NB_SUBS-1:0] sub_hresp;
  // Window configuration
  haddr_t  [2:1]         start_addr;
  haddr_t  [2:1]         end_addr;

  ahb_node i_ahb_node (
    .hclk            (hclk),
    .reset_i         (reset_i),
    .haddr_i         (haddr_i),
    .hwdata_i        (hwdata_i),
    .hsel_i          (hsel_i),
    .hwrite_i        (hwrite_i),
    .htrans_i        (htrans_i),
    .hsize_i         (hsize_i),
    .hrdata_o        (hrdata_o),
    .hready_o        (hready_o),
    .hresp_o         (hresp_o),
    .sub_haddr_o     (sub_haddr),
    .sub_hwdata_o    (sub_hwdata),
    .sub_hsel_o      (sub_hsel),
    .sub_hwrite_o    (sub_hwrite),
    .sub_htrans_o    (sub_htrans),
    .sub_hsize_o     (sub_hsize),
    .sub_hready_o    (sub_hready),
    .sub_hrdata_i    (sub_hrdata),
    .sub_hreadyout_i (sub_hreadyout),
    .sub_hresp_i     (sub_hresp),
    .start_addr_i    (start_addr),
    .end_addr_i      (end_addr)
  );

  // Subordinate 0, window registers
  ahb_amap_regs i_ahb_amap_regs (
    .hclk         (hclk),
    .reset_i      (reset_i),
    .haddr_i      (sub_haddr[0]),
    .hwdata_i     (sub_hwdata[0]),
    .hsel_i       (sub_hsel[0]),
    .hwrite_i     (sub_hwrite[0]),
    .htrans_i     (sub_htrans[0]),
    .hready_i     (sub_hready[0]),
    .hrdata_o     (sub_hrdata[0]),
    .hreadyout_o  (sub_hreadyout[0]),
    .hresp_o      (sub_hresp[0]),
    .start_addr_o (start_addr),
    .end_addr_o   (end_addr)
  );

  // Subordinate 1, no wait states
  ahb_sram_sub #(
    .WAIT_STATES (0),
    .MEM_WORDS   (1024)
  ) i_ahb_sram_sub_1 (
    .hclk        (hclk),
    .reset_i     (reset_i),
    .haddr_i     (sub_haddr[1]),
    .hwdata_i    (sub_hwdata[1]),
    .hsel_i      (sub_hsel[1]),
    .hwrite_i    (sub_hwrite[1]),
    .htrans_i    (sub_htrans[1]),
    .hsize_i     (sub_hsize[1]),
    .hready_i    (sub_hready[1]),
    .hrdata_o    (sub_hrdata[1]),
    .hreadyout_o (sub_hreadyout[1]),
    .hresp_o     (sub_hresp[1])
  );

  // Subordinate 2, two wait states
  ahb_sram_sub #(
    .WAIT_STATES (2),
    .MEM_WORDS   (1024)
  ) i_ahb_sram_sub_2 (
    .hclk        (hclk),
    .reset_i     (reset_i),
    .haddr_i     (sub_haddr[2]),
    .hwdata_i    (sub_hwdata[2]),
    .hsel_i      (sub_hsel[2]),
    .hwrite_i    (sub_hwrite[2]),
    .htrans_i    (sub_htrans[2]),
    .hsize_i     (sub_hsize[2]),
    .hready_i    (sub_hready[2]),
    .hrdata_o    (sub_hrdata[2]),
    .hreadyout_o (sub_hreadyout[2]),
    .hresp_o     (sub_hresp[2])
  );

endmodule

`default_nettype wire

//--- tb_ahb_node_wrap.sv
// Testbench for the AHB-Lite node top level
// Pipelined bus driver, reference model of windows and memories, data-phase checker
`timescale 1ns/1ns
`default_nettype none

module tb_ahb_node_wrap;
  import ahb_pkg::*;

  localparam int N_DIRECTED  = 80;
  localparam int N_RANDOM    = 300;
  // Slowest transfer plus an idle takes four cycles with reset on top
  localparam int CYCLE_LIMIT = 4 * (N_DIRECTED + N_RANDOM) + 20;

  logic    hclk;
  logic    reset_i;
  haddr_t  haddr_i;
  hdata_t  hwdata_i;
  logic    hsel_i;
  logic    hwrite_i;
  htrans_e htrans_i;
  hsize_e  hsize_i;
  hdata_t  hrdata_o;
  logic    hready_o;
  logic    hresp_o;

  // Model of the window registers and both memories
  haddr_t     m_start [1:2];
  haddr_t     m_end   [1:2];
  hdata_t     mem_model [1:2][1024];
  logic       pend_valid;
  logic [7:0] pend_ofs;
  hdata_t     pend_data;

  // Data phase being tracked by the checker
  logic   dp_active;
  int     dp_cycles;
  haddr_t dp_addr;
  logic   dp_write;
  hsize_e dp_size;
  logic   dp_overlap;
  logic   first_resp;
  logic   done_now;
  hdata_t exp_data;
  logic   exp_resp;
  int     exp_lat;

  integer seed;
  int     errors;
  int     n_checked;
  int     cycle_cnt;
  hdata_t next_wdata;

  ahb_node_wrap i_ahb_node_wrap (
    .hclk     (hclk),
    .reset_i  (reset_i),
    .haddr_i  (haddr_i),
    .hwdata_i (hwdata_i),
    .hsel_i   (hsel_i),
    .hwrite_i (hwrite_i),
    .htrans_i (htrans_i),
    .hsize_i  (hsize_i),
    .hrdata_o (hrdata_o),
    .hready_o (hready_o),
    .hresp_o  (hresp_o)
  );

  always #50 hclk = ~hclk;

  // Window write lands at the end of its data phase
  function automatic void commit_window_write();
    if (pend_valid) begin
      case (pend_ofs)
        8'h00:   m_start[1] = pend_data;
        8'h04:   m_end[1]   = pend_data;
        8'h08:   m_start[2] = pend_data;
        8'h0C:   m_end[2]   = pend_data;
        default: ;
      endcase
      pend_valid = 1'b0;
    end
  endfunction

  // Expected read data, response and data-phase length of one transfer
  function automatic hdata_t expected_response(input haddr_t addr, input logic wr,
                                               input hsize_e size, input hdata_t wdata,
                                               input logic overlap, output logic resp,
                                               output int lat);
    int     sub;
    haddr_t ofs;
    hdata_t word;
    // A previous write that is already finished steers this decode
    if (!overlap) begin
      commit_window_write();
    end
    sub = -1;
    ofs = '0;
    if (addr <= 32'h0000_00FF) begin
      sub = 0;
      ofs = addr;
    end
    for (int s = 1; s <= 2; s++) begin
      if (sub < 0 && m_start[s] <= m_end[s] && addr >= m_start[s] && addr <= m_end[s]) begin
        sub = s;
        ofs = addr - m_start[s];
      end
    end
    // Data phase sees the write of the transfer before
    commit_window_write();
    resp = HRESP_OKAY;
    lat  = 1;
    word = '0;
    if (sub == 0) begin
      if (wr) begin
        pend_valid = 1'b1;
        pend_ofs   = ofs[7:0];
        pend_data  = wdata;
      end else begin
        case (ofs[7:0])
          8'h00:   word = m_start[1];
          8'h04:   word = m_end[1];
          8'h08:   word = m_start[2];
          8'h0C:   word = m_end[2];
          default: word = '0;
        endcase
      end
    end else if (sub > 0) begin
      lat  = (sub == 2) ? 3 : 1;
      word = mem_model[sub][ofs[11:2]];
      if (wr) begin
        for (int b = 0; b < 4; b++) begin
          if (size == WORD || (size == HALF && b[1] == ofs[1]) ||
              (size == BYTE && b[1:0] == ofs[1:0])) begin
            word[8*b +: 8] = wdata[8*b +: 8];
          end
        end
        mem_model[sub][ofs[11:2]] = word;
      end
    end else begin
      // Unmapped address gets a two-cycle ERROR
      resp = HRESP_ERROR;
      lat  = 2;
    end
    return word;
  endfunction

  // Checker samples at the falling edge where everything is settled
  always @(negedge hclk) begin
    if (reset_i) begin
      dp_active = 1'b0;
    end else begin
      done_now = 1'b0;
      if (dp_active) begin
        dp_cycles++;
        if (dp_cycles == 1) begin
          first_resp = hresp_o;
        end
        if (hready_o) begin
          exp_data = expected_response(dp_addr, dp_write, dp_size, hwdata_i, dp_overlap,
                                       exp_resp, exp_lat);
          if (hresp_o !== exp_resp) begin
            $display("[ERROR] %0t: addr %h hresp %b, expected %b",
                     $time, dp_addr, hresp_o, exp_resp);
            errors++;
          end
          if (dp_cycles != exp_lat) begin
            $display("[ERROR] %0t: addr %h took %0d cycles, expected %0d",
                     $time, dp_addr, dp_cycles, exp_lat);
            errors++;
          end
          if (exp_lat == 2 && first_resp !== HRESP_ERROR) begin
            $display("[ERROR] %0t: addr %h first ERROR cycle missing", $time, dp_addr);
            errors++;
          end
          if (!dp_write && exp_resp == HRESP_OKAY && hrdata_o !== exp_data) begin
            $display("[ERROR] %0t: addr %h read %h, expected %h",
                     $time, dp_addr, hrdata_o, exp_data);
            errors++;
          end
          n_checked++;
          dp_active = 1'b0;
          done_now  = 1'b1;
        end
      end
      if (hsel_i && hready_o && (htrans_i == NONSEQ || htrans_i == SEQ)) begin
        dp_active  = 1'b1;
        dp_cycles  = 0;
        dp_addr    = haddr_i;
        dp_write   = hwrite_i;
        dp_size    = hsize_i;
        dp_overlap = done_now;
      end
    end
  end

  always @(posedge hclk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, transfers stopped completing", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Returns a small delay after the edge that accepted the address phase
  task automatic wait_ready();
    do begin
      @(negedge hclk);
    end while (!hready_o);
    @(posedge hclk);
    #1;
  endtask

  task automatic bus_transfer(input haddr_t addr, input logic wr, input hsize_e size,
                              input hdata_t wdata, input htrans_e trans);
    hsel_i   = 1'b1;
    htrans_i = trans;
    haddr_i  = addr;
    hwrite_i = wr;
    hsize_i  = size;
    // Write data of the previous transfer
    hwdata_i = next_wdata;
    wait_ready();
    next_wdata = wdata;
  endtask

  task automatic bus_idle();
    htrans_i = IDLE;
    hwrite_i = 1'b0;
    hwdata_i = next_wdata;
    wait_ready();
    next_wdata = '0;
  endtask

  task automatic write_data(input haddr_t addr, input hsize_e size, input hdata_t data);
    bus_transfer(addr, 1'b1, size, data, NONSEQ);
  endtask

  task automatic read_word(input haddr_t addr);
    bus_transfer(addr, 1'b0, WORD, '0, NONSEQ);
  endtask

  initial begin
    logic [31:0] rnd;
    haddr_t      base;
    logic [1:0]  lo;
    hsize_e      sz;
    hclk       = 1'b0;
    reset_i    = 1'b1;
    haddr_i    = '0;
    hwdata_i   = '0;
    hsel_i     = 1'b0;
    hwrite_i   = 1'b0;
    htrans_i   = IDLE;
    hsize_i    = WORD;
    seed       = 32'h00576525;
    errors     = 0;
    n_checked  = 0;
    cycle_cnt  = 0;
    next_wdata = '0;
    m_start[1] = 32'h0000_1000;
    m_end[1]   = 32'h0000_1FFF;
    m_start[2] = 32'h0000_2000;
    m_end[2]   = 32'h0000_2FFF;
    pend_valid = 1'b0;
    pend_ofs   = '0;
    pend_data  = '0;
    for (int s = 1; s <= 2; s++) begin
      for (int w = 0; w < 1024; w++) begin
        mem_model[s][w] = '0;
      end
    end
    repeat (4) @(posedge hclk);
    #1;
    reset_i = 1'b0;
    if (!hready_o || hresp_o !== HRESP_OKAY) begin
      $display("[ERROR] %0t: bus not ready and OKAY after reset", $time);
      errors++;
    end

    // Reset windows then one unused offset
    for (int i = 0; i < 5; i++) begin
      read_word(4 * i);
    end

    // Word accesses in both memories
    for (int s = 1; s <= 2; s++) begin
      base = (s == 1) ? 32'h0000_1000 : 32'h0000_2000;
      write_data(base, WORD, 32'hCAFE_0000 + s);
      write_data(base + 32'h10, WORD, 32'h1234_5678 * s);
      write_data(base + 32'hFFC, WORD, 32'hDEAD_BEE0 | s);
      read_word(base);
      read_word(base + 32'h10);
      read_word(base + 32'hFFC);
    end

    // Byte and halfword lanes
    for (int s = 1; s <= 2; s++) begin
      base = (s == 1) ? 32'h0000_1000 : 32'h0000_2000;
      for (int b = 0; b < 4; b++) begin
        write_data(base + 32'h40 + b, BYTE, 32'h1122_3344 + 32'h0101_0101 * b);
      end
      write_data(base + 32'h44, HALF, 32'hAAAA_5555);
      write_data(base + 32'h46, HALF, 32'h7777_8888);
      write_data(base + 32'h48, WORD, 32'hFFFF_FFFF);
      write_data(base + 32'h49, BYTE, 32'h0000_0000);
      read_word(base + 32'h40);
      read_word(base + 32'h44);
      read_word(base + 32'h48);
    end

    // Unmapped space leaves the memories untouched
    write_data(32'h0000_3000, WORD, 32'hBAD0_0001);
    write_data(32'h0000_0100, WORD, 32'hBAD0_0002);
    read_word(32'h0000_3000);
    read_word(32'hFFFF_FFFC);
    read_word(32'h0000_1000);
    read_word(32'h0000_2000);

    // Memory 1 moved up
    write_data(32'h0000_0000, WORD, 32'h0000_8000);
    write_data(32'h0000_0004, WORD, 32'h0000_8FFF);
    read_word(32'h0000_1000);
    read_word(32'h0000_1000);
    read_word(32'h0000_8000);
    read_word(32'h0000_8010);
    read_word(32'h0000_8040);
    // Lower index wins where memory 1 covers memory 2
    write_data(32'h0000_0000, WORD, 32'h0000_2000);
    write_data(32'h0000_0004, WORD, 32'h0000_2FFF);
    bus_idle();
    read_word(32'h0000_2000);
    read_word(32'h0000_2FFC);
    // End below start
    write_data(32'h0000_0000, WORD, 32'h0000_3000);
    bus_idle();
    read_word(32'h0000_1000);
    read_word(32'h0000_2000);
    write_data(32'h0000_0000, WORD, 32'h0000_1000);
    write_data(32'h0000_0004, WORD, 32'h0000_1FFF);
    for (int i = 0; i < 4; i++) begin
      read_word(4 * i);
    end

    // Random mix over all windows and the gap
    for (int n = 0; n < N_RANDOM; n++) begin
      rnd = $random(seed);
      case (rnd[9:8])
        2'd0: begin
          sz = BYTE;
          lo = rnd[11:10];
        end
        2'd1: begin
          sz = HALF;
          lo = {rnd[11], 1'b0};
        end
        default: begin
          sz = WORD;
          lo = 2'b00;
        end
      endcase
      case (rnd[2:0])
        3'd1, 3'd2, 3'd3: base = 32'h0000_1000;
        3'd7:             base = 32'h0000_3000 + {12'h0, rnd[27:20], 12'h000};
        default:          base = 32'h0000_2000;
      endcase
      if (rnd[2:0] == 3'd0) begin
        bus_transfer({27'h0, rnd[5:3], 2'b00}, 1'b0, WORD, '0, NONSEQ);
      end else begin
        bus_transfer(base + {24'h0, rnd[7:2], lo}, rnd[12], sz, $random(seed),
                     rnd[16] ? SEQ : NONSEQ);
      end
      if (rnd[15:13] == 3'd0) begin
        bus_idle();
      end
    end

    bus_idle();
    while (dp_active) begin
      @(posedge hclk);
    end
    repeat (2) @(posedge hclk);
    $display("Summary: %0d data phases checked, %0d errors", n_checked, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
ahb_pkg.sv
amap_pkg.sv
ahb_node.sv
ahb_amap_regs.sv
ahb_sram_sub.sv
ahb_node_wrap.sv
tb_ahb_node_wrap.sv

//--- run.sh
#!/bin/sh
# Build and run the AHB node testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_ahb_node_wrap -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
